//--- include/median_settings.svh
// median filter settings
// window geometry, pixel width, threshold and pipeline depth
`ifndef MEDIAN_SETTINGS_SVH
`define MEDIAN_SETTINGS_SVH

// window side, the window holds MED_WIN x MED_WIN pixels
`define MED_WIN 5

// bits per pixel
`define MED_PIX_W 8

// median strictly above this value sets the binary output
`define MED_THRESHOLD 5

// input den to output med_den, in cycles
// window register, two rank stages, output register
`define MED_LATENCY 4

`endif

//--- source/pixel_pkg.sv
// pixel data types
// single pixel, packed 5x5 window and rank count
`include "median_settings.svh"

package pixel_pkg;

  // one video sample
  typedef logic [`MED_PIX_W-1:0] pixel_t;

  // row-major window, pixel (r,c) at index r*MED_WIN+c
  typedef logic [`MED_WIN*`MED_WIN*`MED_PIX_W-1:0] window_t;

  // number of window values ranked below a given one, 0..24
  typedef logic [4:0] rank_t;

endpackage

//--- source/video_pkg.sv
// video timing types
// column fill count and window fill state
package video_pkg;

  // columns entered since the last sync, saturates at 4
  typedef logic [2:0] col_count_t;

  // fill state of the sliding window within a line
  typedef enum logic [1:0] {
    WIN_EMPTY,
    WIN_FILLING,
    WIN_FULL
  } fill_state_t;

endpackage

//--- source/window_if.sv
// window bus
// full 5x5 window with valid strobe and aligned sync levels
`timescale 1ns/100ps

interface window_if;

  pixel_pkg::window_t win;
  // one strobe per complete window
  logic               win_valid;
  logic               vsync;
  logic               hsync;

  modport src (output win, win_valid, vsync, hsync);

  modport dst (input win, win_valid, vsync, hsync);

endinterface

//--- source/result_if.sv
// median result bus
// median value with valid strobe and aligned sync levels
`timescale 1ns/100ps

interface result_if;

  pixel_pkg::pixel_t median;
  logic              med_valid;
  logic              vsync;
  logic              hsync;

  modport src (output median, med_valid, vsync, hsync);

  modport dst (input median, med_valid, vsync, hsync);

endinterface

//--- source/pixel_window.sv
// sliding 5x5 pixel window
// shifts in one column of line pixels per enabled cycle, tracks fill per line
`timescale 1ns/100ps
`include "median_settings.svh"

module pixel_window (
  input  logic              ref_clk,
  input  logic              rst_n,
  input  logic              den,
  input  logic              vsync,
  input  logic              hsync,
  input  pixel_pkg::pixel_t line_0,
  input  pixel_pkg::pixel_t line_1,
  input  pixel_pkg::pixel_t line_2,
  input  pixel_pkg::pixel_t line_3,
  input  pixel_pkg::pixel_t line_4,
  window_if.src             win_out
);

  localparam int WIN = `MED_WIN;

  pixel_pkg::pixel_t      line_col [WIN];
  pixel_pkg::pixel_t      pix_q [WIN][WIN];
  video_pkg::col_count_t  col_cnt;
  video_pkg::fill_state_t state;
  video_pkg::fill_state_t state_nxt;
  logic                   sync_clr;

  // line k feeds window row k
  assign line_col[0] = line_0;
  assign line_col[1] = line_1;
  assign line_col[2] = line_2;
  assign line_col[3] = line_3;
  assign line_col[4] = line_4;

  assign sync_clr = vsync | hsync;

  // column 0 is the oldest, the new column enters on the right
  always_ff @(posedge ref_clk) begin
    if (den) begin
      for (int r = 0; r < WIN; r++) begin
        for (int c = 0; c < WIN - 1; c++) begin
          pix_q[r][c] <= pix_q[r][c+1];
        end
        pix_q[r][WIN-1] <= line_col[r];
      end
    end
  end

  always_comb begin
    for (int r = 0; r < WIN; r++) begin
      for (int c = 0; c < WIN; c++) begin
        win_out.win[(r*WIN+c)*`MED_PIX_W +: `MED_PIX_W] = pix_q[r][c];
      end
    end
  end

  // fill state, full once the fifth pixel of a line arrives
  always_comb begin
    state_nxt = state;
    case (state)
      video_pkg::WIN_EMPTY: begin
        if (den) begin
          state_nxt = video_pkg::WIN_FILLING;
        end
      end
      video_pkg::WIN_FILLING: begin
        if (den && col_cnt == video_pkg::col_count_t'(WIN - 1)) begin
          state_nxt = video_pkg::WIN_FULL;
        end
      end
      default: begin
        state_nxt = state;
      end
    endcase
    // any sync level restarts the line
    if (sync_clr) begin
      state_nxt = video_pkg::WIN_EMPTY;
    end
  end

  always_ff @(posedge ref_clk or negedge rst_n) begin
    if (!rst_n) begin
      state             <= video_pkg::WIN_EMPTY;
      col_cnt           <= '0;
      win_out.win_valid <= 1'b0;
      win_out.vsync     <= 1'b0;
      win_out.hsync     <= 1'b0;
    end else begin
      state <= state_nxt;
      if (sync_clr) begin
        col_cnt <= '0;
      end else if (den && col_cnt != video_pkg::col_count_t'(WIN - 1)) begin
        col_cnt <= col_cnt + video_pkg::col_count_t'(1);
      end
      win_out.win_valid <= den & (state_nxt == video_pkg::WIN_FULL);
      win_out.vsync     <= vsync;
      win_out.hsync     <= hsync;
    end
  end

endmodule

//--- source/median_rank.sv
// rank based median of the 25 window values
// stage 1 ranks every position, stage 2 picks the middle rank
`timescale 1ns/100ps
`include "median_settings.svh"

module median_rank (
  input  logic  ref_clk,
  input  logic  rst_n,
  window_if.dst win_in,
  result_if.src med_out
);

  localparam int N   = `MED_WIN * `MED_WIN;
  localparam int MID = N / 2;
  localparam int PW  = `MED_PIX_W;

  pixel_pkg::pixel_t pix_in [N];
  pixel_pkg::rank_t  rank_nxt [N];
  pixel_pkg::pixel_t pix_s1 [N];
  pixel_pkg::rank_t  rank_s1 [N];
  logic              valid_s1;
  logic              vsync_s1;
  logic              hsync_s1;
  pixel_pkg::pixel_t median_sel;

  always_comb begin
    for (int i = 0; i < N; i++) begin
      pix_in[i] = win_in.win[i*PW +: PW];
    end
  end

  // count of values ranked below position i
  // earlier positions count when equal, later ones only when smaller,
  // so equal values get distinct ranks and the ranks form 0..N-1
  always_comb begin
    logic below;
    for (int i = 0; i < N; i++) begin
      rank_nxt[i] = '0;
      for (int j = 0; j < N; j++) begin
        below = (j < i) ? (pix_in[j] <= pix_in[i]) : (pix_in[j] < pix_in[i]);
        if (below) begin
          rank_nxt[i] = rank_nxt[i] + pixel_pkg::rank_t'(1);
        end
      end
    end
  end

  // stage 1 payload
  always_ff @(posedge ref_clk) begin
    for (int i = 0; i < N; i++) begin
      pix_s1[i]  <= pix_in[i];
      rank_s1[i] <= rank_nxt[i];
    end
  end

  always_ff @(posedge ref_clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_s1 <= 1'b0;
      vsync_s1 <= 1'b0;
      hsync_s1 <= 1'b0;
    end else begin
      valid_s1 <= win_in.win_valid;
      vsync_s1 <= win_in.vsync;
      hsync_s1 <= win_in.hsync;
    end
  end

  // exactly one position holds rank MID
  always_comb begin
    median_sel = '0;
    for (int i = 0; i < N; i++) begin
      if (rank_s1[i] == pixel_pkg::rank_t'(MID)) begin
        median_sel = median_sel | pix_s1[i];
      end
    end
  end

  // stage 2
  always_ff @(posedge ref_clk) begin
    med_out.median <= median_sel;
  end

  always_ff @(posedge ref_clk or negedge rst_n) begin
    if (!rst_n) begin
      med_out.med_valid <= 1'b0;
      med_out.vsync     <= 1'b0;
      med_out.hsync     <= 1'b0;
    end else begin
      med_out.med_valid <= valid_s1;
      med_out.vsync     <= vsync_s1;
      med_out.hsync     <= hsync_s1;
    end
  end

endmodule

//--- source/binarize_out.sv
// output stage
// registers the median, its threshold bit and the delayed sync levels
`timescale 1ns/100ps
`include "median_settings.svh"

module binarize_out (
  input  logic              ref_clk,
  input  logic              rst_n,
  result_if.dst             med_in,
  output pixel_pkg::pixel_t med_value,
  output logic              med_bin,
  output logic              med_den,
  output logic              med_vsync,
  output logic              med_hsync
);

  always_ff @(posedge ref_clk or negedge rst_n) begin
    if (!rst_n) begin
      med_value <= '0;
      med_bin   <= 1'b0;
      med_den   <= 1'b0;
      med_vsync <= 1'b0;
      med_hsync <= 1'b0;
    end else begin
      med_den   <= med_in.med_valid;
      med_vsync <= med_in.vsync;
      med_hsync <= med_in.hsync;
      // value and bit hold between results
      if (med_in.med_valid) begin
        med_value <= med_in.median;
        med_bin   <= (med_in.median > pixel_pkg::pixel_t'(`MED_THRESHOLD));
      end
    end
  end

endmodule

//--- source/median_filter_top.sv
// 5x5 median filter top level
// window, rank median and output stages, MED_LATENCY cycles from den to med_den
`timescale 1ns/100ps

module median_filter_top (
  input  logic              ref_clk,
  input  logic              rst_n,
  input  logic              den,
  input  logic              vsync,
  input  logic              hsync,
  input  pixel_pkg::pixel_t line_0,
  input  pixel_pkg::pixel_t line_1,
  input  pixel_pkg::pixel_t line_2,
  input  pixel_pkg::pixel_t line_3,
  input  pixel_pkg::pixel_t line_4,
  output pixel_pkg::pixel_t med_value,
  output logic              med_bin,
  output logic              med_den,
  output logic              med_vsync,
  output logic              med_hsync
);

  window_if win_bus ();
  result_if med_bus ();

  // one cycle, window register
  pixel_window i_pixel_window (
    .ref_clk (ref_clk),
    .rst_n   (rst_n),
    .den     (den),
    .vsync   (vsync),
    .hsync   (hsync),
    .line_0  (line_0),
    .line_1  (line_1),
    .line_2  (line_2),
    .line_3  (line_3),
    .line_4  (line_4),
    .win_out (win_bus.src)
  );

  // two cycles, rank then select
  median_rank i_median_rank (
    .ref_clk (ref_clk),
    .rst_n   (rst_n),
    .win_in  (win_bus.dst),
    .med_out (med_bus.src)
  );

  binarize_out i_binarize_out (
    .ref_clk   (ref_clk),
    .rst_n     (rst_n),
    .med_in    (med_bus.dst),
    .med_value (med_value),
    .med_bin   (med_bin),
    .med_den   (med_den),
    .med_vsync (med_vsync),
    .med_hsync (med_hsync)
  );

endmodule

//--- tests/tb_median_filter.sv
// median filter testbench
// random short frames against a sorting reference model, checked by assertions
`timescale 1ns/100ps
`include "median_settings.svh"

module tb_median_filter;

  localparam int WIN           = `MED_WIN;
  localparam int LAT           = `MED_LATENCY;
  localparam int DRAIN_TIMEOUT = 200;
  localparam int MODE_RANDOM   = 0;
  localparam int MODE_RUNS     = 1;
  localparam int MODE_LOW      = 2;

  logic              ref_clk;
  logic              rst_n;
  logic              den;
  logic              vsync;
  logic              hsync;
  pixel_pkg::pixel_t line_0;
  pixel_pkg::pixel_t line_1;
  pixel_pkg::pixel_t line_2;
  pixel_pkg::pixel_t line_3;
  pixel_pkg::pixel_t line_4;
  pixel_pkg::pixel_t med_value;
  logic              med_bin;
  logic              med_den;
  logic              med_vsync;
  logic              med_hsync;

  // reference model, columns since the last sync, newest at WIN-1
  pixel_pkg::pixel_t           col_hist [WIN][WIN];
  int                          fill_cnt;
  logic [LAT-1:0]              exp_den_q;
  pixel_pkg::pixel_t [LAT-1:0] exp_med_q;
  logic [LAT-1:0]              vs_q;
  logic [LAT-1:0]              hs_q;

  logic [31:0]       rng_state   = 32'hb086;
  pixel_pkg::pixel_t run_val     = '0;
  int                run_left    = 0;
  int                err_count   = 0;
  int                exp_results = 0;
  int                got_results = 0;
  logic              out_seen    = 1'b0;

  median_filter_top i_dut (
    .ref_clk   (ref_clk),
    .rst_n     (rst_n),
    .den       (den),
    .vsync     (vsync),
    .hsync     (hsync),
    .line_0    (line_0),
    .line_1    (line_1),
    .line_2    (line_2),
    .line_3    (line_3),
    .line_4    (line_4),
    .med_value (med_value),
    .med_bin   (med_bin),
    .med_den   (med_den),
    .med_vsync (med_vsync),
    .med_hsync (med_hsync)
  );

  initial begin
    ref_clk = 1'b0;
    forever begin
      #20 ref_clk = ~ref_clk;
    end
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic pixel_pkg::pixel_t rand_pixel(input int mode);
    logic [31:0] r;
    r = next_rand();
    if (mode == MODE_LOW) begin
      return pixel_pkg::pixel_t'(r % 32'd11);
    end
    if (mode == MODE_RUNS) begin
      if (run_left == 0) begin
        run_val  = r[7:0];
        run_left = 1 + int'(r[10:8]);
      end
      run_left--;
      return run_val;
    end
    return r[7:0];
  endfunction

  // 13th smallest by insertion sort
  function automatic pixel_pkg::pixel_t median_of(input pixel_pkg::pixel_t v [WIN*WIN]);
    pixel_pkg::pixel_t s [WIN*WIN];
    pixel_pkg::pixel_t key;
    int                j;
    s = v;
    for (int i = 1; i < WIN * WIN; i++) begin
      key = s[i];
      j = i - 1;
      while (j >= 0 && s[j] > key) begin
        s[j+1] = s[j];
        j--;
      end
      s[j+1] = key;
    end
    return s[(WIN*WIN)/2];
  endfunction

  always @(posedge ref_clk or negedge rst_n) begin : ref_model
    pixel_pkg::pixel_t vals [WIN*WIN];
    logic              now_valid;
    pixel_pkg::pixel_t now_med;
    if (!rst_n) begin
      fill_cnt = 0;
      exp_den_q <= '0;
      exp_med_q <= '0;
      vs_q      <= '0;
      hs_q      <= '0;
    end else begin
      now_valid = 1'b0;
      now_med   = '0;
      if (vsync || hsync) begin
        fill_cnt = 0;
      end else if (den) begin
        for (int c = 0; c < WIN - 1; c++) begin
          for (int r = 0; r < WIN; r++) begin
            col_hist[c][r] = col_hist[c+1][r];
          end
        end
        col_hist[WIN-1][0] = line_0;
        col_hist[WIN-1][1] = line_1;
        col_hist[WIN-1][2] = line_2;
        col_hist[WIN-1][3] = line_3;
        col_hist[WIN-1][4] = line_4;
        if (fill_cnt < WIN) begin
          fill_cnt++;
        end
        if (fill_cnt == WIN) begin
          for (int c = 0; c < WIN; c++) begin
            for (int r = 0; r < WIN; r++) begin
              vals[c*WIN+r] = col_hist[c][r];
            end
          end
          now_valid = 1'b1;
          now_med   = median_of(vals);
        end
      end
      exp_den_q <= {exp_den_q[LAT-2:0], now_valid};
      exp_med_q <= {exp_med_q[LAT-2:0], now_med};
      vs_q      <= {vs_q[LAT-2:0], vsync};
      hs_q      <= {hs_q[LAT-2:0], hsync};
    end
  end

  always @(posedge ref_clk) begin
    if (rst_n && med_den) begin
      got_results <= got_results + 1;
      out_seen    <= 1'b1;
    end
  end

  // mid-cycle check while reset is held
  reset_low: assert property (@(negedge ref_clk)
    !rst_n |-> (!med_den && !med_bin && !med_vsync && !med_hsync))
    else begin
      err_count++;
      $display("FAIL %0t: outputs not low during reset", $time);
    end

  bin_idle_low: assert property (@(posedge ref_clk) disable iff (!rst_n)
    (!out_seen && !med_den) |-> !med_bin)
    else begin
      err_count++;
      $display("FAIL %0t: med_bin high before the first result", $time);
    end

  den_timing: assert property (@(posedge ref_clk) disable iff (!rst_n)
    med_den == exp_den_q[LAT-1])
    else begin
      err_count++;
      $display("FAIL %0t: med_den %0b, expected %0b", $time,
               $sampled(med_den), $sampled(exp_den_q[LAT-1]));
    end

  median_value: assert property (@(posedge ref_clk) disable iff (!rst_n)
    med_den |-> (med_value == exp_med_q[LAT-1]))
    else begin
      err_count++;
      $display("FAIL %0t: med_value %0d, expected %0d", $time,
               $sampled(med_value), $sampled(exp_med_q[LAT-1]));
    end

  threshold_bit: assert property (@(posedge ref_clk) disable iff (!rst_n)
    med_den |-> (med_bin == (exp_med_q[LAT-1] > pixel_pkg::pixel_t'(`MED_THRESHOLD))))
    else begin
      err_count++;
      $display("FAIL %0t: med_bin %0b for median %0d", $time,
               $sampled(med_bin), $sampled(exp_med_q[LAT-1]));
    end

  sync_delay: assert property (@(posedge ref_clk) disable iff (!rst_n)
    (med_vsync == vs_q[LAT-1]) && (med_hsync == hs_q[LAT-1]))
    else begin
      err_count++;
      $display("FAIL %0t: sync vs %0b hs %0b, expected vs %0b hs %0b", $time,
               $sampled(med_vsync), $sampled(med_hsync),
               $sampled(vs_q[LAT-1]), $sampled(hs_q[LAT-1]));
    end

  task automatic drive_cycle(input logic den_v, input logic vs_v, input logic hs_v,
                             input int mode);
    @(posedge ref_clk);
    den    <= den_v;
    vsync  <= vs_v;
    hsync  <= hs_v;
    line_0 <= rand_pixel(mode);
    line_1 <= rand_pixel(mode);
    line_2 <= rand_pixel(mode);
    line_3 <= rand_pixel(mode);
    line_4 <= rand_pixel(mode);
  endtask

  task automatic idle(input int n);
    for (int i = 0; i < n; i++) begin
      drive_cycle(1'b0, 1'b0, 1'b0, MODE_RANDOM);
    end
  endtask

  task automatic vsync_pulse();
    drive_cycle(1'b0, 1'b1, 1'b0, MODE_RANDOM);
    drive_cycle(1'b0, 1'b1, 1'b0, MODE_RANDOM);
  endtask

  task automatic hsync_pulse();
    drive_cycle(1'b0, 1'b0, 1'b1, MODE_RANDOM);
  endtask

  // n enabled pixels, optionally with single idle cycles between them
  task automatic send_line(input int n, input int mode, input logic gaps);
    if (n > WIN - 1) begin
      exp_results += n - (WIN - 1);
    end
    for (int p = 0; p < n; p++) begin
      if (gaps && (next_rand() & 32'd1) != 0) begin
        idle(1);
      end
      drive_cycle(1'b1, 1'b0, 1'b0, mode);
    end
  endtask

  task automatic wait_for_results();
    int cycles;
    cycles = 0;
    while (got_results < exp_results && cycles < DRAIN_TIMEOUT) begin
      @(posedge ref_clk);
      cycles++;
    end
    if (got_results < exp_results) begin
      $display("timeout: only %0d of %0d results arrived", got_results, exp_results);
      err_count++;
    end
  endtask

  initial begin : stimulus
    int len;
    rst_n  <= 1'b0;
    den    <= 1'b0;
    vsync  <= 1'b0;
    hsync  <= 1'b0;
    line_0 <= '0;
    line_1 <= '0;
    line_2 <= '0;
    line_3 <= '0;
    line_4 <= '0;
    repeat (3) @(posedge ref_clk);
    rst_n <= 1'b1;
    idle(3);
    // first frame, random lines of 12 to 20 pixels
    vsync_pulse();
    for (int l = 0; l < 4; l++) begin
      len = 12 + int'(next_rand() % 32'd9);
      hsync_pulse();
      send_line(len, MODE_RANDOM, 1'b0);
      idle(2 + l);
    end
    // many equal values in one window
    hsync_pulse();
    send_line(18, MODE_RUNS, 1'b0);
    idle(3);
    // values 0 to 10 around the threshold
    hsync_pulse();
    send_line(20, MODE_LOW, 1'b0);
    idle(3);
    // never fills
    hsync_pulse();
    send_line(4, MODE_RANDOM, 1'b0);
    idle(2);
    // hsync in mid-stream restarts the fill count
    hsync_pulse();
    send_line(9, MODE_RANDOM, 1'b0);
    hsync_pulse();
    send_line(12, MODE_LOW, 1'b0);
    idle(3);
    // second frame, idle cycles inside the lines
    vsync_pulse();
    for (int l = 0; l < 3; l++) begin
      len = 12 + int'(next_rand() % 32'd9);
      hsync_pulse();
      send_line(len, (l == 1) ? MODE_RUNS : MODE_RANDOM, 1'b1);
      idle(2);
    end
    wait_for_results();
    idle(LAT + 2);
    result_count: assert (got_results == exp_results)
      else begin
        err_count++;
        $display("FAIL %0t: %0d results, expected %0d", $time, got_results, exp_results);
      end
    $display("results %0d of %0d, errors %0d", got_results, exp_results, err_count);
    if (err_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+include
source/pixel_pkg.sv
source/video_pkg.sv
source/window_if.sv
source/result_if.sv
source/pixel_window.sv
source/median_rank.sv
source/binarize_out.sv
source/median_filter_top.sv
tests/tb_median_filter.sv

//--- Makefile
# Verilator build and run for the median filter testbench

VERILATOR ?= verilator
TOP       ?= tb_median_filter
FILE_LIST ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= test passed

SOURCES := $(shell grep -v '^+' $(FILE_LIST)) $(wildcard include/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)

# pass only when the simulator prints the pass line
run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
